// ==== project.f ====
+incdir+common
+incdir+sim
common/bus_pkg.sv
common/map_pkg.sv
fabric/addr_decode.sv
fabric/slave_route.sv
fabric/resp_merge.sv
hdl/rst_debounce.sv
hdl/soc_bus_top.sv
sim/tb_soc_bus_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bus fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f project.f --top-module tb_soc_bus_top -o tb_sim

# The simulator exits nonzero on failure, the log decides
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== sim/tb_helpers.svh ====
/*
 * Testbench helpers
 *  - Galois LFSR and random bit draws
 *  - slave model data, reference decode and read data
 *  - value check and run abort
 */
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

logic [31:0] lfsr_q = 32'h573b_495a;

// Io ports near the interesting windows
localparam logic [15:0] IO_PICK [12] = '{
  16'h03C0, 16'h03F8, 16'h0060, 16'h0064, 16'h0100, 16'hF100,
  16'hF200, 16'h0040, 16'h0238, 16'h0210, 16'hF300, 16'h0500
};

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    v      = {v[30:0], lfsr_q[0]};
  end
  return v;
endfunction

function automatic logic [15:0] slave_data(input logic [3:0] id, input logic [19:1] adr);
  if (id == 4'd4) begin
    return {8'h00, 4'h4, adr[4:1]};  // Audio port is 8 bits wide
  end
  return {id, adr[12:1]};
endfunction

// 0..10 external port, 11 absorbing, 12 default
function automatic int ref_target(input bus_req_t r);
  logic [19:0] b;
  logic [15:0] p;
  b = {r.adr, 1'b0};
  p = b[15:0];
  if (!r.io) begin
    if (b >= 20'hFFE00) return 0;
    if (b >= 20'hA0000 && b <= 20'hBFFFF) return 1;
    return 10;
  end
  if (p >= 16'h03C0 && p <= 16'h03DF) return 1;
  if (p >= 16'h03F8 && p <= 16'h03FF) return 2;
  if (p == 16'h0060 || p == 16'h0064) return r.sel[1] && p == 16'h0060 ? 4 : 3;
  if (p == 16'h0100 || p == 16'h0101) return 5;
  if (p >= 16'hF100 && p <= 16'hF103) return 6;
  if (p >= 16'hF200 && p <= 16'hF20F) return 7;
  if (p >= 16'h0040 && p <= 16'h0043) return 8;
  if (p >= 16'h0238 && p <= 16'h023B) return 9;
  if (p >= 16'h0210 && p <= 16'h021F) return 11;
  if (p >= 16'hF300 && p <= 16'hF3FF) return 11;
  return 12;
endfunction

function automatic logic [15:0] ref_data(input bus_req_t r, input intack_t ia);
  int          t;
  logic [15:0] aud;
  logic [15:0] kbd;
  t   = ref_target(r);
  aud = slave_data(4'd4, r.adr);
  kbd = slave_data(4'd3, r.adr);
  if (ia.nmia) return 16'h0002;
  if (ia.inta) return 16'h0008 + {13'd0, ia.iid};
  if (t >= 11) return 16'h0000;
  if (t == 4) return {aud[7:0], kbd[7:0]};  // Audio byte over keyboard low byte
  return slave_data(t[3:0], r.adr);
endfunction

task automatic stop_run(input string why);
  $display("%s", why);
  $display("Regression failed");
  $fatal(1, "run stopped");
endtask

task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (act !== exp) begin
    stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  end
endtask

`endif

// ==== sim/tb_soc_bus_top.sv ====
/*
 * Testbench of the bus fabric top level
 *  - clock, reset, random master requests, slave models
 *  - comparing process for port requests and read data
 */
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module tb_soc_bus_top;

  import bus_pkg::*;

  localparam int HOLD = 8;  // Reset hold of the DUT in cycles

  logic     clk;
  logic     rst_lck;
  bus_req_t mst_req_i;
  bus_rsp_t mst_rsp_o;
  bus_req_t slv_req_o [`SOC_NUM_SLV];
  bus_rsp_t slv_rsp_i [`SOC_NUM_SLV];
  intack_t  intack_i;

  logic [`SOC_NUM_SLV-1:0] stb_vec;
  logic [`SOC_NUM_SLV-1:0] ack_q;
  logic [`SOC_NUM_SLV-1:0] busy_q;
  logic [1:0]              dly_q [`SOC_NUM_SLV];

  logic                    xfer_on;   // Comparing process active
  string                   test_name;
  logic [`SOC_NUM_SLV-1:0] exp_stb;
  logic [15:0]             exp_dat;

  `include "tb_helpers.svh"

  soc_bus_top #(
    .hold_cycles (HOLD)
  ) dut (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .mst_req_i (mst_req_i),
    .mst_rsp_o (mst_rsp_o),
    .slv_req_o (slv_req_o),
    .slv_rsp_i (slv_rsp_i),
    .intack_i  (intack_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always_comb begin
    for (int i = 0; i < `SOC_NUM_SLV; i++) begin
      stb_vec[i]          = slv_req_o[i].cyc & slv_req_o[i].stb;
      slv_rsp_i[i].dat    = slave_data(4'(i), slv_req_o[i].adr);  // Always valid
      slv_rsp_i[i].ack    = ack_q[i];
    end
  end

  // Slave models, ack after 0..3 wait cycles
  always @(posedge clk) begin
    for (int i = 0; i < `SOC_NUM_SLV; i++) begin
      if (ack_q[i]) begin
        ack_q[i] <= 1'b0;
      end else if (busy_q[i]) begin
        if (dly_q[i] == 2'd0) begin
          ack_q[i]  <= 1'b1;
          busy_q[i] <= 1'b0;
        end else begin
          dly_q[i] <= dly_q[i] - 2'd1;
        end
      end else if (stb_vec[i]) begin
        busy_q[i] <= 1'b1;
        dly_q[i]  <= 2'(rand_bits(2));
      end
    end
  end

  // Comparing process, samples mid-cycle
  always @(negedge clk) begin
    if (xfer_on) begin
      check_ports(test_name, exp_stb, mst_req_i);
      if (mst_rsp_o.ack) begin
        check_val({test_name, " data"}, 64'(exp_dat), 64'(mst_rsp_o.dat));
      end
    end
  end

  // Every port carries the master request, cyc and stb only where selected
  task automatic check_ports(input string name, input logic [`SOC_NUM_SLV-1:0] sel,
                             input bus_req_t r);
    bus_req_t e;
    for (int i = 0; i < `SOC_NUM_SLV; i++) begin
      e     = r;
      e.cyc = r.cyc & sel[i];
      e.stb = r.stb & sel[i];
      check_val($sformatf("%s port %0d", name, i), 64'(e), 64'(slv_req_o[i]));
    end
  endtask

  task automatic wait_ack(input string name);
    logic done;
    done = 1'b0;
    for (int n = 0; n < 64 && !done; n++) begin
      @(negedge clk);
      done = mst_rsp_o.ack;
    end
    if (!done) stop_run({"Timeout: no ack seen in test ", name});
  endtask

  task automatic run_xfer(input string name, input bus_req_t r, input intack_t ia);
    int t;
    @(posedge clk);
    mst_req_i <= r;
    intack_i  <= ia;
    t         = ref_target(r);
    test_name = name;
    exp_stb   = (t < `SOC_NUM_SLV) ? `SOC_NUM_SLV'(1) << t : '0;
    exp_dat   = ref_data(r, ia);
    xfer_on   = 1'b1;
    wait_ack(name);
    @(posedge clk);
    mst_req_i.cyc <= 1'b0;  // One idle cycle between transfers
    mst_req_i.stb <= 1'b0;
    intack_i      <= '0;
    xfer_on       = 1'b0;
  endtask

  function automatic bus_req_t make_req();
    bus_req_t    r;
    logic [31:0] v;
    logic [19:0] b;
    logic [15:0] p;
    r = '0;
    v = rand_bits(5);
    if (v[4]) begin
      p = (v[3:0] < 4'd12) ? IO_PICK[v[3:0]] + 16'(rand_bits(4)) : 16'(rand_bits(16));
      b = {4'h0, p};
    end else if (v[1:0] == 2'd0) begin
      b = 20'hFFE00 + 20'(rand_bits(9));
    end else if (v[1:0] == 2'd1) begin
      b = 20'hA0000 + 20'(rand_bits(16));
    end else begin
      b = 20'(rand_bits(20));
    end
    r.io  = v[4];
    r.adr = b[19:1];
    r.dat = 16'(rand_bits(16));
    r.sel = 2'(rand_bits(2));
    if (r.sel == 2'b00) r.sel = 2'b11;
    r.we  = rand_bits(1) != 0;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    return r;
  endfunction

  function automatic bus_req_t io_req(input logic [15:0] port, input logic [1:0] sel);
    bus_req_t r;
    r     = '0;
    r.io  = 1'b1;
    r.adr = {4'h0, port[15:1]};
    r.sel = sel;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    return r;
  endfunction

  initial begin
    bus_req_t r;
    rst_lck   = 1'b0;
    mst_req_i = '0;
    intack_i  = '0;
    ack_q     = '0;
    busy_q    = '0;
    xfer_on   = 1'b0;
    test_name = "";
    exp_stb   = '0;
    exp_dat   = '0;
    for (int i = 0; i < `SOC_NUM_SLV; i++) dly_q[i] = 2'd0;

    // Request held through the reset window, which ends
    // hold_cycles + 1 cycles after rst_lck is seen high
    r = io_req(16'h03F8, 2'b11);
    repeat (2) @(posedge clk);
    rst_lck   <= 1'b1;
    mst_req_i <= r;
    for (int k = 0; k < HOLD + 2; k++) begin
      @(negedge clk);
      check_ports("reset", '0, r);
      check_val("reset ack", 64'd0, 64'(mst_rsp_o.ack));
    end
    run_xfer("first after reset", r, '0);

    for (int n = 0; n < 300; n++) begin
      run_xfer("random", make_req(), '0);
    end

    r     = '0;
    r.adr = 19'h7FF80;  // ROM wins over RAM
    r.sel = 2'b11;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    run_xfer("rom priority", r, '0);

    run_xfer("absorb sb", io_req(16'h0214, 2'b11), '0);
    run_xfer("absorb sdc", io_req(16'hF380, 2'b01), '0);
    run_xfer("default io", io_req(16'h0500, 2'b11), '0);

    run_xfer("audio", io_req(16'h0060, 2'b10), '0);
    run_xfer("audio word", io_req(16'h0060, 2'b11), '0);
    run_xfer("keyboard", io_req(16'h0060, 2'b01), '0);
    run_xfer("keyboard 64", io_req(16'h0064, 2'b10), '0);

    run_xfer("nmi ack", make_req(), '{nmia: 1'b1, inta: 1'b1, iid: 3'd5});
    for (int i = 0; i < 8; i++) begin
      run_xfer("int ack", make_req(), '{nmia: 1'b0, inta: 1'b1, iid: 3'(i)});
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/soc_bus_top.sv ====
/*
 * Bus fabric top level
 *  - reset debounce, address decode, request routing, response merge
 */
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module soc_bus_top #(
  parameter int hold_cycles = `SOC_RST_HOLD
) (
  input  logic              clk,
  input  logic              rst_lck,

  // Master side
  input  bus_pkg::bus_req_t mst_req_i,
  output bus_pkg::bus_rsp_t mst_rsp_o,

  // Slave ports, indexed by slave_id_e
  output bus_pkg::bus_req_t slv_req_o [`SOC_NUM_SLV],
  input  bus_pkg::bus_rsp_t slv_rsp_i [`SOC_NUM_SLV],

  input  bus_pkg::intack_t  intack_i
);

  import map_pkg::*;

  logic       rst;      // Internal reset, active high
  slave_sel_t sel;      // One-hot target of the current request
  logic       int_ack;  // Ack of the built-in slaves

  rst_debounce #(
    .hold_cycles (hold_cycles)
  ) u_rst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (rst)
  );

  addr_decode u_decode (
    .req_i (mst_req_i),
    .sel_o (sel)
  );

  slave_route u_route (
    .clk       (clk),
    .rst_i     (rst),
    .req_i     (mst_req_i),
    .sel_i     (sel),
    .slv_req_o (slv_req_o),
    .int_ack_o (int_ack)
  );

  resp_merge u_merge (
    .sel_i     (sel),
    .slv_rsp_i (slv_rsp_i),
    .int_ack_i (int_ack),
    .intack_i  (intack_i),
    .rst_i     (rst),
    .mst_rsp_o (mst_rsp_o)
  );

endmodule

`default_nettype wire

// ==== hdl/rst_debounce.sv ====
/*
 * Reset debounce
 *  - samples the external reset and holds the internal one for
 *    hold_cycles after release
 */
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module rst_debounce #(
  parameter int hold_cycles = `SOC_RST_HOLD
) (
  input  logic clk,
  input  logic rst_lck,
  output logic rst_o
);

  localparam int CNT_W = (hold_cycles < 1) ? 1 : $clog2(hold_cycles + 1);

  logic             rst_lck_q;  // Sampled button/lock level
  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    rst_lck_q <= rst_lck;

    // Counter restarts for every low sample, so bounces extend the hold
    if (!rst_lck_q) begin
      cnt <= CNT_W'(hold_cycles);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end

    rst_o <= !rst_lck_q || (cnt != '0);
  end

endmodule

`default_nettype wire

// ==== fabric/resp_merge.sv ====
/*
 * Response merge
 *  - OR of data and ack over the selected slaves
 *  - audio byte merged with the keyboard low byte
 *  - NMI and interrupt vector overrides on the read data
 */
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module resp_merge (
  input  map_pkg::slave_sel_t sel_i,
  input  bus_pkg::bus_rsp_t   slv_rsp_i [`SOC_NUM_SLV],
  input  logic                int_ack_i,
  input  bus_pkg::intack_t    intack_i,
  input  logic                rst_i,
  output bus_pkg::bus_rsp_t   mst_rsp_o
);

  import map_pkg::*;

  localparam logic [`SOC_DATA_W-1:0] NMI_VEC      = 16'h0002;
  localparam logic [`SOC_DATA_W-1:0] INT_VEC_BASE = 16'h0008;

  logic [`SOC_DATA_W-1:0] kaud_dat;  // Audio high byte, keyboard low byte
  logic [`SOC_DATA_W-1:0] bus_dat;
  logic                   bus_ack;

  assign kaud_dat = {slv_rsp_i[SLV_AUD].dat[7:0], slv_rsp_i[SLV_KBD].dat[7:0]};

  always_comb begin
    bus_dat = '0;        // Built-in slaves read as zero
    bus_ack = int_ack_i;
    for (int i = 0; i < `SOC_NUM_SLV; i++) begin
      if (sel_i.slv[i] && (i != int'(SLV_AUD))) begin
        bus_dat = bus_dat | slv_rsp_i[i].dat;
        bus_ack = bus_ack | slv_rsp_i[i].ack;
      end
    end
    if (sel_i.slv[SLV_AUD]) begin
      bus_dat = bus_dat | kaud_dat;
      bus_ack = bus_ack | slv_rsp_i[SLV_AUD].ack;
    end
  end

  // Acknowledge cycles read the vector instead of the bus
  always_comb begin
    mst_rsp_o.ack = bus_ack & ~rst_i;
    if (intack_i.nmia) begin
      mst_rsp_o.dat = NMI_VEC;
    end else if (intack_i.inta) begin
      mst_rsp_o.dat = INT_VEC_BASE + {{(`SOC_DATA_W-3){1'b0}}, intack_i.iid};
    end else begin
      mst_rsp_o.dat = bus_dat;
    end
  end

endmodule

`default_nettype wire

// ==== fabric/slave_route.sv ====
/*
 * Request fan-out
 *  - request copied to all slave ports, cyc/stb only on the selected one
 *  - built-in absorbing and default slaves
 */
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module slave_route (
  input  logic                clk,
  input  logic                rst_i,
  input  bus_pkg::bus_req_t   req_i,
  input  map_pkg::slave_sel_t sel_i,
  output bus_pkg::bus_req_t   slv_req_o [`SOC_NUM_SLV],
  output logic                int_ack_o
);

  logic int_req;    // Built-in slave addressed with cyc and stb high
  logic int_ack_q;  // Ack given in the previous cycle

  always_comb begin
    for (int i = 0; i < `SOC_NUM_SLV; i++) begin
      slv_req_o[i]     = req_i;
      slv_req_o[i].cyc = req_i.cyc & sel_i.slv[i] & ~rst_i;
      slv_req_o[i].stb = req_i.stb & sel_i.slv[i] & ~rst_i;
    end
  end

  assign int_req = req_i.cyc & req_i.stb & (sel_i.absorb | sel_i.dflt) & ~rst_i;

  // Zero wait states, but only one ack per strobe
  assign int_ack_o = int_req & ~int_ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      int_ack_q <= 1'b0;
    end else begin
      int_ack_q <= int_ack_o;
    end
  end

endmodule

`default_nettype wire

// ==== fabric/addr_decode.sv ====
/*
 * Address decoder
 *  - region table built from the map constants
 *  - priority select, keyboard/audio split, absorbing and default fallbacks
 */
`timescale 1ns/100ps
`default_nettype none

`include "soc_defines.svh"

module addr_decode (
  input  bus_pkg::bus_req_t   req_i,
  output map_pkg::slave_sel_t sel_o
);

  import map_pkg::*;

  // Table rows in priority order
  typedef enum int {
    R_ROM,
    R_VGAM,
    R_VGAIO,
    R_UART,
    R_KBD,
    R_SD,
    R_GPIO,
    R_CSR,
    R_TMR,
    R_FLASH,
    R_SB,
    R_SDC,
    R_RAM,
    R_NUM
  } region_idx_e;

  localparam region_t REGION_TBL [R_NUM] = '{
    '{`SOC_ROM_BASE,   `SOC_ROM_MASK},
    '{`SOC_VGAM_BASE,  `SOC_VGAM_MASK},
    '{`SOC_VGAIO_BASE, `SOC_VGAIO_MASK},
    '{`SOC_UART_BASE,  `SOC_UART_MASK},
    '{`SOC_KBD_BASE,   `SOC_KBD_MASK},
    '{`SOC_SD_BASE,    `SOC_SD_MASK},
    '{`SOC_GPIO_BASE,  `SOC_GPIO_MASK},
    '{`SOC_CSR_BASE,   `SOC_CSR_MASK},
    '{`SOC_TMR_BASE,   `SOC_TMR_MASK},
    '{`SOC_FLASH_BASE, `SOC_FLASH_MASK},
    '{`SOC_SB_BASE,    `SOC_SB_MASK},
    '{`SOC_SDC_BASE,   `SOC_SDC_MASK},
    '{`SOC_RAM_BASE,   `SOC_RAM_MASK}
  };

  logic [REG_W-1:0] tag;      // {io flag, word address}
  logic [R_NUM-1:0] hit;
  logic             kbd_aud;  // Port 0x61 goes to the audio slave

  assign tag     = {req_i.io, req_i.adr};
  assign kbd_aud = (req_i.adr[2:1] == 2'b00) && req_i.sel[1];

  always_comb begin
    for (int i = 0; i < R_NUM; i++) begin
      hit[i] = ((tag & REGION_TBL[i].mask) == REGION_TBL[i].base);
    end
  end

  // First hit wins, so ROM shadows RAM
  always_comb begin
    sel_o = '0;
    if (hit[R_ROM]) begin
      sel_o.slv[SLV_ROM] = 1'b1;
    end else if (hit[R_VGAM] || hit[R_VGAIO]) begin
      sel_o.slv[SLV_VGA] = 1'b1;
    end else if (hit[R_UART]) begin
      sel_o.slv[SLV_UART] = 1'b1;
    end else if (hit[R_KBD]) begin
      sel_o.slv[kbd_aud ? SLV_AUD : SLV_KBD] = 1'b1;
    end else if (hit[R_SD]) begin
      sel_o.slv[SLV_SD] = 1'b1;
    end else if (hit[R_GPIO]) begin
      sel_o.slv[SLV_GPIO] = 1'b1;
    end else if (hit[R_CSR]) begin
      sel_o.slv[SLV_CSR] = 1'b1;
    end else if (hit[R_TMR]) begin
      sel_o.slv[SLV_TMR] = 1'b1;
    end else if (hit[R_FLASH]) begin
      sel_o.slv[SLV_FLASH] = 1'b1;
    end else if (hit[R_SB] || hit[R_SDC]) begin
      sel_o.absorb = 1'b1;              // Windows with no device behind them
    end else if (hit[R_RAM]) begin
      sel_o.slv[SLV_RAM] = 1'b1;        // Any memory left over
    end else begin
      sel_o.dflt = 1'b1;                // Unmapped io
    end
  end

endmodule

`default_nettype wire

// ==== common/map_pkg.sv ====
/*
 * Address map types
 *  - slave_id_e   external slave port numbers
 *  - slave_sel_t  one-hot target incl. absorbing and default slaves
 *  - region_t     base/mask pair of one decode region
 */
`default_nettype none

`include "soc_defines.svh"

package map_pkg;

  // Width of a region tag, io flag plus word address
  localparam int REG_W = `SOC_ADR_W + 1;

  // Port numbers, also the bit positions in slave_sel_t.slv
  typedef enum logic [3:0] {
    SLV_ROM   = 4'd0,
    SLV_VGA   = 4'd1,   // Video memory and video io
    SLV_UART  = 4'd2,
    SLV_KBD   = 4'd3,
    SLV_AUD   = 4'd4,   // Shares the keyboard window
    SLV_SD    = 4'd5,
    SLV_GPIO  = 4'd6,
    SLV_CSR   = 4'd7,
    SLV_TMR   = 4'd8,
    SLV_FLASH = 4'd9,
    SLV_RAM   = 4'd10
  } slave_id_e;

  // Exactly one bit is set per request
  typedef struct packed {
    logic                    dflt;    // No region matched
    logic                    absorb;  // Sound-card or SDRAM-control window
    logic [`SOC_NUM_SLV-1:0] slv;
  } slave_sel_t;

  // A tag matches when (tag & mask) == base
  typedef struct packed {
    logic [REG_W-1:0] base;
    logic [REG_W-1:0] mask;
  } region_t;

endpackage

`default_nettype wire

// ==== common/bus_pkg.sv ====
/*
 * Types of the 16-bit master/slave bus
 *  - bus_req_t  master request, also copied to every slave port
 *  - bus_rsp_t  slave response
 *  - intack_t   interrupt and NMI acknowledge from the CPU side
 */
`default_nettype none

`include "soc_defines.svh"

package bus_pkg;

  // Request, 41 bits
  typedef struct packed {
    logic                  io;   // 1 for io space, 0 for memory
    logic [`SOC_ADR_W:1]   adr;  // Word address
    logic [`SOC_DATA_W-1:0] dat; // Write data
    logic [`SOC_SEL_W-1:0]  sel; // Byte select, bit 1 is the high byte
    logic                  we;
    logic                  cyc;
    logic                  stb;
  } bus_req_t;

  // Response, 17 bits
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] dat; // Read data
    logic                   ack; // One cycle per transfer
  } bus_rsp_t;

  // Interrupt acknowledge inputs, 5 bits
  typedef struct packed {
    logic       nmia;  // NMI acknowledge cycle
    logic       inta;  // Interrupt acknowledge cycle
    logic [2:0] iid;   // Interrupt number from the controller
  } intack_t;

endpackage

`default_nettype wire

// ==== common/soc_defines.svh ====
/*
 * Bus fabric constants
 *  - data, address and byte-select widths, slave port count
 *  - reset hold length
 *  - base/mask pairs of the address map, {io flag, word address}
 */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

`define SOC_DATA_W   16
`define SOC_ADR_W    19      // Word address, bits 19..1
`define SOC_SEL_W    2
`define SOC_NUM_SLV  11
`define SOC_RST_HOLD 131071  // About 10 ms at 12.5 MHz

// Memory regions
`define SOC_ROM_BASE   20'h7FF00  // mem 0xFFE00 - 0xFFFFF
`define SOC_ROM_MASK   20'hFFF00
`define SOC_VGAM_BASE  20'h50000  // mem 0xA0000 - 0xBFFFF
`define SOC_VGAM_MASK  20'hF0000

// Io regions, upper four address bits ignored
`define SOC_VGAIO_BASE 20'h801E0  // io 0x3C0 - 0x3DF
`define SOC_VGAIO_MASK 20'h87FF0
`define SOC_UART_BASE  20'h801FC  // io 0x3F8 - 0x3FF
`define SOC_UART_MASK  20'h87FFC
`define SOC_KBD_BASE   20'h80030  // io 0x60 and 0x64
`define SOC_KBD_MASK   20'h87FFD
`define SOC_SD_BASE    20'h80080  // io 0x100 - 0x101
`define SOC_SD_MASK    20'h87FFF
`define SOC_GPIO_BASE  20'h87880  // io 0xF100 - 0xF103
`define SOC_GPIO_MASK  20'h87FFE
`define SOC_CSR_BASE   20'h87900  // io 0xF200 - 0xF20F
`define SOC_CSR_MASK   20'h87FF8
`define SOC_TMR_BASE   20'h80020  // io 0x40 - 0x43
`define SOC_TMR_MASK   20'h87FFE
`define SOC_FLASH_BASE 20'h8011C  // io 0x238 - 0x23B
`define SOC_FLASH_MASK 20'h87FFE
`define SOC_SB_BASE    20'h80108  // io 0x210 - 0x21F, sound card
`define SOC_SB_MASK    20'h87FF8
`define SOC_SDC_BASE   20'h87980  // io 0xF300 - 0xF3FF, SDRAM control
`define SOC_SDC_MASK   20'h87F80

// Whole memory space
`define SOC_RAM_BASE   20'h00000
`define SOC_RAM_MASK   20'h80000

`endif
